// ==== source/spr_pkg.sv ====
package spr_pkg;

   // Bus widths
   localparam int spr_addr_w  = 16;
   localparam int spr_data_w  = 32;
   localparam int tt_cmp_w    = 28;  // Low TTCR bits seen by the compare
   localparam int irq_lines_n = 8;

   // SPR map, group 10 timer and group 9 PIC
   localparam logic [spr_addr_w-1:0] ttmr_addr  = 16'h5000;
   localparam logic [spr_addr_w-1:0] ttcr_addr  = 16'h5001;
   localparam logic [spr_addr_w-1:0] picmr_addr = 16'h4800;
   localparam logic [spr_addr_w-1:0] picsr_addr = 16'h4802;

   // TTMR layout
   localparam int ttmr_ip_bit   = 28;  // Interrupt pending
   localparam int ttmr_ie_bit   = 29;  // Interrupt enable
   localparam int ttmr_mode_lsb = 30;  // Two bit mode field, 31:30

   // Timer mode, encoding fixed by TTMR[31:30]
   typedef enum logic [1:0] {
      tt_disabled   = 2'd0,
      tt_restart    = 2'd1,  // Back to zero on match
      tt_stop       = 2'd2,  // Freeze on match
      tt_continuous = 2'd3   // Keep counting through match
   } tt_mode_e;

   // Target of a decoded SPR address
   typedef enum logic [1:0] {
      unit_none  = 2'd0,
      unit_timer = 2'd1,
      unit_pic   = 2'd2
   } spr_unit_e;

endpackage

// ==== source/spr_bridge.sv ====
`timescale 1ns/1ps

module spr_bridge (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           req_valid_i,
   input  logic                           req_we_i,
   input  logic [spr_pkg::spr_addr_w-1:0] req_addr_i,
   input  logic [spr_pkg::spr_data_w-1:0] req_wdata_i,
   output logic                           req_ready_o,
   output logic                           rsp_valid_o,
   output logic [spr_pkg::spr_data_w-1:0] rsp_rdata_o,
   input  logic                           rsp_ready_i,
   output logic [spr_pkg::spr_addr_w-1:0] spr_addr_o,
   output logic [spr_pkg::spr_data_w-1:0] spr_wdata_o,
   output logic                           spr_we_o,
   output logic                           timer_sel_o,
   output logic                           pic_sel_o,
   input  logic [spr_pkg::spr_data_w-1:0] timer_rdata_i,
   input  logic [spr_pkg::spr_data_w-1:0] pic_rdata_i
);
   import spr_pkg::*;

   // One access at a time, no pipelining
   typedef enum logic [1:0] {
      st_idle,    // Waiting for a request
      st_strobe,  // Select high, unit sees the access
      st_resp     // Response held until taken
   } state_e;

   state_e                state_q;
   logic                  we_q;
   logic [spr_addr_w-1:0] addr_q;
   logic [spr_data_w-1:0] wdata_q;
   spr_unit_e             unit_q;     // Decoded once at accept
   logic [spr_data_w-1:0] rdata_q;    // Held response data
   spr_unit_e             unit_dec;
   logic [spr_data_w-1:0] rdata_mux;
   logic                  accept;

   assign accept = req_valid_i && req_ready_o;

   // Address decode on the incoming request
   always_comb
   begin
      case (req_addr_i)
         ttmr_addr, ttcr_addr:   unit_dec = unit_timer;
         picmr_addr, picsr_addr: unit_dec = unit_pic;
         default:                unit_dec = unit_none;  // Unmapped, reads zero
      endcase
   end

   // Writes answer with zero
   always_comb
   begin
      rdata_mux = '0;
      if (!we_q)
      begin
         case (unit_q)
            unit_timer: rdata_mux = timer_rdata_i;
            unit_pic:   rdata_mux = pic_rdata_i;
            default:    rdata_mux = '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state_q <= st_idle;
      else
      begin
         case (state_q)
            st_idle:
               if (accept)
                  state_q <= st_strobe;
            st_strobe:
               state_q <= st_resp;  // Strobe lasts exactly one cycle
            st_resp:
               if (rsp_ready_i)
                  state_q <= st_idle;
            default:
               state_q <= st_idle;
         endcase
      end
   end

   // Request and response payload
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         we_q    <= req_we_i;
         addr_q  <= req_addr_i;
         wdata_q <= req_wdata_i;
         unit_q  <= unit_dec;
      end
      if (state_q == st_strobe)
         rdata_q <= rdata_mux;  // Value just before the write edge
   end

   assign req_ready_o = (state_q == st_idle);
   assign rsp_valid_o = (state_q == st_resp);
   assign rsp_rdata_o = rdata_q;
   assign spr_addr_o  = addr_q;
   assign spr_wdata_o = wdata_q;
   assign spr_we_o    = we_q;   // Qualified by the selects
   assign timer_sel_o = (state_q == st_strobe) && (unit_q == unit_timer);
   assign pic_sel_o   = (state_q == st_strobe) && (unit_q == unit_pic);

   // Response must not drop or change before the handshake
   assert property (@(posedge clk) disable iff (rst)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o));

   // Never two units at once
   assert property (@(posedge clk) disable iff (rst)
      $onehot0({timer_sel_o, pic_sel_o}));

endmodule

// ==== source/tick_timer.sv ====
`timescale 1ns/1ps

module tick_timer (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           sel_i,
   input  logic                           we_i,
   input  logic [spr_pkg::spr_addr_w-1:0] addr_i,
   input  logic [spr_pkg::spr_data_w-1:0] wdata_i,
   output logic [spr_pkg::spr_data_w-1:0] rdata_o,
   output logic                           tick_irq_o
);
   import spr_pkg::*;

   logic [spr_data_w-1:0] ttmr_q;
   logic [spr_data_w-1:0] ttcr_q;
   logic                  ttmr_wr;
   logic                  ttcr_wr;
   logic                  match;
   logic                  ie;
   logic                  ip;
   tt_mode_e              mode;

   // Bridge has already checked the range, bit 0 picks the register
   assign ttmr_wr = sel_i && we_i && !addr_i[0];
   assign ttcr_wr = sel_i && we_i && addr_i[0];

   assign mode  = tt_mode_e'(ttmr_q[ttmr_mode_lsb +: 2]);
   assign ie    = ttmr_q[ttmr_ie_bit];
   assign ip    = ttmr_q[ttmr_ip_bit];
   assign match = (ttcr_q[tt_cmp_w-1:0] == ttmr_q[tt_cmp_w-1:0]);  // 28 bit compare

   // TTMR, software write wins over IP set
   always_ff @(posedge clk)
   begin
      if (rst)
         ttmr_q <= '0;
      else if (ttmr_wr)
         ttmr_q <= wdata_i;  // Also the only way to clear IP
      else if (match && ie)
         ttmr_q[ttmr_ip_bit] <= 1'b1;
   end

   // TTCR, free running per mode
   always_ff @(posedge clk)
   begin
      if (rst)
         ttcr_q <= '0;
      else if (ttcr_wr)
         ttcr_q <= wdata_i;
      else if (match)
      begin
         case (mode)
            tt_restart:    ttcr_q <= '0;
            tt_continuous: ttcr_q <= ttcr_q + 1'b1;
            default:       ttcr_q <= ttcr_q;  // Stop and disabled hold
         endcase
      end
      else if (mode != tt_disabled)
         ttcr_q <= ttcr_q + 1'b1;  // Stop mode climbs up to the match
   end

   assign rdata_o    = addr_i[0] ? ttcr_q : ttmr_q;
   assign tick_irq_o = ip && ie;

   // With IE clear only a TTMR write may raise IP
   assert property (@(posedge clk) disable iff (rst)
      !ttmr_wr && !ie && !ip |=> !ip);

endmodule

// ==== source/pic_unit.sv ====
`timescale 1ns/1ps

module pic_unit (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            sel_i,
   input  logic                            we_i,
   input  logic [spr_pkg::spr_addr_w-1:0]  addr_i,
   input  logic [spr_pkg::spr_data_w-1:0]  wdata_i,
   input  logic [spr_pkg::irq_lines_n-1:0] irq_lines_i,
   output logic [spr_pkg::spr_data_w-1:0]  rdata_o,
   output logic                            pic_irq_o
);
   import spr_pkg::*;

   logic [irq_lines_n-1:0] picmr_q;  // Mask, one bit per line
   logic [irq_lines_n-1:0] picsr_q;  // Latched status
   logic [irq_lines_n-1:0] clr;
   logic                   picmr_wr;
   logic                   picsr_wr;

   // PICMR at 0x4800, PICSR at 0x4802
   assign picmr_wr = sel_i && we_i && !addr_i[1];
   assign picsr_wr = sel_i && we_i && addr_i[1];

   // Write one to clear
   assign clr = picsr_wr ? wdata_i[irq_lines_n-1:0] : '0;

   always_ff @(posedge clk)
   begin
      if (rst)
         picmr_q <= '0;
      else if (picmr_wr)
         picmr_q <= wdata_i[irq_lines_n-1:0];
   end

   // Level OR after clear, so a line still high wins
   always_ff @(posedge clk)
   begin
      if (rst)
         picsr_q <= '0;
      else
         picsr_q <= (picsr_q & ~clr) | irq_lines_i;
   end

   // Zero extended readback
   always_comb
   begin
      rdata_o = '0;
      if (addr_i[1])
         rdata_o[irq_lines_n-1:0] = picsr_q;
      else
         rdata_o[irq_lines_n-1:0] = picmr_q;
   end

   assign pic_irq_o = |(picsr_q & picmr_q);

   // Masking everything silences the output on the next cycle
   assert property (@(posedge clk) disable iff (rst)
      picmr_wr && (wdata_i[irq_lines_n-1:0] == '0) |=> !pic_irq_o);

endmodule

// ==== source/timer_subsystem_top.sv ====
`timescale 1ns/1ps

module timer_subsystem_top (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            req_valid_i,
   input  logic                            req_we_i,
   input  logic [spr_pkg::spr_addr_w-1:0]  req_addr_i,
   input  logic [spr_pkg::spr_data_w-1:0]  req_wdata_i,
   output logic                            req_ready_o,
   output logic                            rsp_valid_o,
   output logic [spr_pkg::spr_data_w-1:0]  rsp_rdata_o,
   input  logic                            rsp_ready_i,
   input  logic [spr_pkg::irq_lines_n-1:0] irq_lines_i,
   output logic                            tick_irq_o,
   output logic                            pic_irq_o
);
   import spr_pkg::*;

   // Shared SPR strobe
   logic [spr_addr_w-1:0] spr_addr;
   logic [spr_data_w-1:0] spr_wdata;
   logic                  spr_we;
   logic                  timer_sel;
   logic                  pic_sel;
   logic [spr_data_w-1:0] timer_rdata;  // Combinational per unit
   logic [spr_data_w-1:0] pic_rdata;

   spr_bridge u_bridge (
      .clk           (clk),
      .rst           (rst),
      .req_valid_i   (req_valid_i),
      .req_we_i      (req_we_i),
      .req_addr_i    (req_addr_i),
      .req_wdata_i   (req_wdata_i),
      .req_ready_o   (req_ready_o),
      .rsp_valid_o   (rsp_valid_o),
      .rsp_rdata_o   (rsp_rdata_o),
      .rsp_ready_i   (rsp_ready_i),
      .spr_addr_o    (spr_addr),
      .spr_wdata_o   (spr_wdata),
      .spr_we_o      (spr_we),
      .timer_sel_o   (timer_sel),
      .pic_sel_o     (pic_sel),
      .timer_rdata_i (timer_rdata),
      .pic_rdata_i   (pic_rdata)
   );

   tick_timer u_tick_timer (
      .clk        (clk),
      .rst        (rst),
      .sel_i      (timer_sel),
      .we_i       (spr_we),
      .addr_i     (spr_addr),
      .wdata_i    (spr_wdata),
      .rdata_o    (timer_rdata),
      .tick_irq_o (tick_irq_o)
   );

   pic_unit u_pic (
      .clk         (clk),
      .rst         (rst),
      .sel_i       (pic_sel),
      .we_i        (spr_we),
      .addr_i      (spr_addr),
      .wdata_i     (spr_wdata),
      .irq_lines_i (irq_lines_i),  // Straight from the pins
      .rdata_o     (pic_rdata),
      .pic_irq_o   (pic_irq_o)
   );

endmodule

// ==== test/tb_timer_subsystem.sv ====
`timescale 1ns/1ps

module tb_timer_subsystem;
   import spr_pkg::*;

   localparam int max_stall    = 6;   // Longest rsp_ready_i hold off
   localparam int reset_cycles = 3;

   logic                   clk;
   logic                   rst;
   logic                   req_valid;
   logic                   req_we;
   logic [spr_addr_w-1:0]  req_addr;
   logic [spr_data_w-1:0]  req_wdata;
   logic                   req_ready;
   logic                   rsp_valid;
   logic [spr_data_w-1:0]  rsp_rdata;
   logic                   rsp_ready;
   logic [irq_lines_n-1:0] irq_lines;
   logic                   tick_irq;
   logic                   pic_irq;

   string       op_q[$];    // One entry per stim line
   logic [31:0] arg0_q[$];
   logic [31:0] arg1_q[$];
   int          err_cnt     = 0;
   int          chk_cnt     = 0;
   int          access_cnt  = 0;
   int          cycle_cnt   = 0;
   int          cycle_limit = 0;
   logic        limit_set   = 1'b0;
   integer      seed        = 61;

   timer_subsystem_top u_dut (
      .clk         (clk),
      .rst         (rst),
      .req_valid_i (req_valid),
      .req_we_i    (req_we),
      .req_addr_i  (req_addr),
      .req_wdata_i (req_wdata),
      .req_ready_o (req_ready),
      .rsp_valid_o (rsp_valid),
      .rsp_rdata_o (rsp_rdata),
      .rsp_ready_i (rsp_ready),
      .irq_lines_i (irq_lines),
      .tick_irq_o  (tick_irq),
      .pic_irq_o   (pic_irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      err_cnt++;
      $display("error: %s expected %h got %h at %0t", name, exp, act, $time);
   endtask

   task automatic note_failure(input string what);
      err_cnt++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Whole file into queues first, so the cycle budget is known up front
   task automatic load_stim(output logic ok);
      int          fd;
      int          code;
      int          idle_sum;
      int          n_access;
      string       op;
      string       rest;
      logic [31:0] a0;
      logic [31:0] a1;
      ok       = 1'b0;
      idle_sum = 0;
      n_access = 0;
      fd = $fopen("test/timer_stim.txt", "r");
      if (fd != 0)
      begin
         ok   = 1'b1;
         code = $fscanf(fd, "%s", op);
         while (code == 1)
         begin
            if (op.getc(0) == "#")
               code = $fgets(rest, fd);  // Column notes
            else
            begin
               a0 = '0;
               a1 = '0;
               if (op == "idle")
                  code = $fscanf(fd, "%d", a0);  // Cycle count in decimal
               else if (op == "irq")
                  code = $fscanf(fd, "%h", a0);
               else
                  code = $fscanf(fd, "%h %h", a0, a1);
               if (op == "idle")
                  idle_sum += int'(a0);
               if (op == "wr" || op == "rd" || op == "rdle")
                  n_access++;
               op_q.push_back(op);
               arg0_q.push_back(a0);
               arg1_q.push_back(a1);
            end
            code = $fscanf(fd, "%s", op);
         end
         $fclose(fd);
         cycle_limit = reset_cycles + idle_sum + n_access * (40 + max_stall);
         limit_set   = 1'b1;
      end
   endtask

   // kind 0 write, 1 exact read, 2 read with upper bound
   task automatic run_access(input logic we, input logic [15:0] addr,
                             input logic [31:0] wdata, input int kind,
                             input logic [31:0] expv);
      logic [31:0] held;
      logic [31:0] rdata;
      int          stall;
      req_valid = 1'b1;
      req_we    = we;
      req_addr  = addr;
      req_wdata = wdata;
      while (!req_ready)
         @(negedge clk);
      @(negedge clk);  // Accepted on the edge in between
      req_valid = 1'b0;
      while (!rsp_valid)
         @(negedge clk);
      held  = rsp_rdata;
      chk_cnt++;
      if (req_ready)
         note_failure("req_ready_o high while a response was pending");
      stall = 0;
      if (access_cnt % 3 == 2)
         stall = int'($unsigned($random(seed)) % (max_stall + 1));
      repeat (stall)
      begin
         @(negedge clk);
         chk_cnt++;
         if (!rsp_valid)
            note_failure("response dropped while rsp_ready_i was low");
         if (rsp_rdata !== held)
            report_mismatch("rsp_rdata_o", held, rsp_rdata);
         if (req_ready)
            note_failure("req_ready_o high while rsp_ready_i was low");
      end
      rdata     = rsp_rdata;
      rsp_ready = 1'b1;
      @(negedge clk);  // Taken on this edge
      rsp_ready = 1'b0;
      access_cnt++;
      chk_cnt++;
      if (rsp_valid)
         note_failure("response still valid after the handshake");
      if (!req_ready)
         note_failure("req_ready_o still low after the response was taken");
      if (kind == 2)
      begin
         if (rdata > expv)
            report_mismatch("rsp_rdata_o (upper bound)", expv, rdata);
      end
      else if (rdata !== expv)
         report_mismatch("rsp_rdata_o", expv, rdata);  // Writes answer zero
   endtask

   initial
   begin
      while (!(limit_set && cycle_cnt > cycle_limit))
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
   end

   initial
   begin
      logic ok;
      string op;
      rst       = 1'b1;
      req_valid = 1'b0;
      req_we    = 1'b0;
      req_addr  = '0;
      req_wdata = '0;
      rsp_ready = 1'b0;
      irq_lines = '0;
      load_stim(ok);
      if (!ok)
      begin
         $display("Could not open the stimulus file test/timer_stim.txt");
         $display("Test FAILED");
         $finish;
      end
      else
      begin
         repeat (reset_cycles)
            @(posedge clk);
         @(negedge clk);
         rst = 1'b0;
         for (int i = 0; i < op_q.size(); i++)
         begin
            op = op_q[i];
            if (op == "wr")
               run_access(1'b1, arg0_q[i][15:0], arg1_q[i], 0, 32'h0);
            else if (op == "rd")
               run_access(1'b0, arg0_q[i][15:0], 32'h0, 1, arg1_q[i]);
            else if (op == "rdle")
               run_access(1'b0, arg0_q[i][15:0], 32'h0, 2, arg1_q[i]);
            else if (op == "idle")
               repeat (int'(arg0_q[i]))
                  @(negedge clk);
            else if (op == "irq")
               irq_lines = arg0_q[i][irq_lines_n-1:0];  // Seen on the next edge
            else if (op == "chk")
            begin
               chk_cnt += 2;
               if (tick_irq !== arg0_q[i][0])
                  report_mismatch("tick_irq_o", {31'b0, arg0_q[i][0]}, {31'b0, tick_irq});
               if (pic_irq !== arg1_q[i][0])
                  report_mismatch("pic_irq_o", {31'b0, arg1_q[i][0]}, {31'b0, pic_irq});
            end
            else
               note_failure({"unknown opcode in stimulus file: ", op});
         end
         $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
         if (err_cnt == 0)
            $display("Test OK");
         else
            $display("Test FAILED");
         $finish;
      end
   end

endmodule

// ==== test/timer_stim.txt ====
# op arg0 arg1: wr addr data | rd addr expected | rdle addr max
# idle cycles (decimal) | irq line levels | chk tick_irq pic_irq
chk  0 0
rd   5000 00000000
rd   5001 00000000
rd   4802 00000000
wr   5000 00001234
rd   5000 00001234
wr   5001 0abcdef0
rd   5001 0abcdef0
wr   4800 000000a5
rd   4800 000000a5
wr   4800 00000000
wr   6000 deadbeef
rd   6000 00000000
rd   1234 00000000
wr   5000 80000014
wr   5001 00000000
idle 30
rd   5001 00000014
rd   5000 80000014
chk  0 0
wr   5001 00000000
wr   5000 a0000014
chk  0 0
idle 30
chk  1 0
rd   5001 00000014
rd   5000 b0000014
wr   5000 80000014
chk  0 0
wr   5000 60000005
wr   5001 00000000
idle 10
chk  1 0
rdle 5001 00000005
wr   5000 00000000
chk  0 0
irq  08
idle 3
irq  00
idle 2
chk  0 0
rd   4802 00000008
wr   4800 00000008
chk  0 1
wr   4802 00000008
rd   4802 00000000
chk  0 0

// ==== project.f ====
source/spr_pkg.sv
source/spr_bridge.sv
source/tick_timer.sv
source/pic_unit.sv
source/timer_subsystem_top.sv
test/tb_timer_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run from the project root, decide on the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f \
   --top-module tb_timer_subsystem -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "Build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Test OK" sim.log && echo "PASS" \
   || { echo "FAIL"; exit 1; }
